//--- include/uart_cmd_cfg.svh
`ifndef UART_CMD_CFG_SVH
`define UART_CMD_CFG_SVH

// System clocks per oversampling tick
`define UART_TICK_DIV    27

// Data bits per frame, LSB first
`define UART_DATA_BITS   8

// Oversampling ticks spent in the stop bit
`define UART_STOP_TICKS  16

// FIFO address width, 16 entries
`define RX_FIFO_AW       4

`endif

//--- rtl/uart_cmd_pkg.sv
`include "uart_cmd_cfg.svh"

package uart_cmd_pkg;

   ////////////////////////////////////////
   // Receiver FSM states
   ////////////////////////////////////////
   typedef enum logic [1:0]
   {
      RX_IDLE  = 2'b00,
      RX_START = 2'b01,
      RX_DATA  = 2'b10,
      RX_STOP  = 2'b11
   } rx_state_t;

   // Opcode bytes, ASCII letters
   typedef enum logic [7:0]
   {
      OP_SET = 8'h53,
      OP_ADD = 8'h41,
      OP_CLR = 8'h43
   } cmd_op_t;

   // Executor states
   typedef enum logic
   {
      EX_OPCODE  = 1'b0,
      EX_OPERAND = 1'b1
   } exec_state_t;

   // One received byte plus its stop-bit status
   typedef struct packed
   {
      logic                        frame_err;
      logic [`UART_DATA_BITS-1:0]  data;
   } rx_entry_t;

endpackage

//--- rtl/baud_tick_gen.sv
`timescale 1ns/1ps
`include "uart_cmd_cfg.svh"

module baud_tick_gen
   (
   input  logic  i_clk,
   input  logic  reset,
   output logic  s_tick
   );

   localparam int DIV   = `UART_TICK_DIV;
   localparam int CNT_W = $clog2(DIV);

   // Free-running divider count
   logic [CNT_W-1:0]  cnt;

   // Last count of the period
   assign s_tick = (cnt == CNT_W'(DIV - 1));

   ////////////////////////////////////////
   // Divider
   ////////////////////////////////////////
   always_ff @(posedge i_clk or posedge reset)
   begin
      if (reset)
      begin
         cnt <= '0;
      end
      else if (s_tick)
      begin
         // Wrap and start next period
         cnt <= '0;
      end
      else
      begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps
`include "uart_cmd_cfg.svh"

module uart_rx
   (
   input  logic                     i_clk,
   input  logic                     reset,
   input  logic                     rx,
   input  logic                     s_tick,
   output logic                     rx_done_tick,
   output uart_cmd_pkg::rx_entry_t  rx_entry
   );

   localparam int DB   = `UART_DATA_BITS;
   localparam int SB   = `UART_STOP_TICKS;
   localparam int N_W  = $clog2(DB);
   // Tick counter must reach 15 for data bits
   localparam int S_W  = ($clog2(SB) > 4) ? $clog2(SB) : 4;

   uart_cmd_pkg::rx_state_t  state_reg, state_next;
   logic [S_W-1:0]           s_reg, s_next;
   logic [N_W-1:0]           n_reg, n_next;
   logic [DB-1:0]            buffer, buffer_next;
   logic                     ferr_reg, ferr_next;
   logic                     done_next;
   // Line synchronizer and edge history
   logic                     rx_meta, rx_sync, rx_prev;

   ////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////
   always_ff @(posedge i_clk or posedge reset)
   begin
      if (reset)
      begin
         state_reg    <= uart_cmd_pkg::RX_IDLE;
         s_reg        <= '0;
         n_reg        <= '0;
         rx_done_tick <= 1'b0;
         // Idle line is high
         rx_meta      <= 1'b1;
         rx_sync      <= 1'b1;
         rx_prev      <= 1'b1;
      end
      else
      begin
         state_reg    <= state_next;
         s_reg        <= s_next;
         n_reg        <= n_next;
         rx_done_tick <= done_next;
         rx_meta      <= rx;
         rx_sync      <= rx_meta;
         rx_prev      <= rx_sync;
      end
   end

   // Shift register and stop status
   always_ff @(posedge i_clk)
   begin
      buffer   <= buffer_next;
      ferr_reg <= ferr_next;
   end

   ////////////////////////////////////////
   // Next-state logic
   ////////////////////////////////////////
   always_comb
   begin
      state_next  = state_reg;
      s_next      = s_reg;
      n_next      = n_reg;
      buffer_next = buffer;
      ferr_next   = ferr_reg;
      done_next   = 1'b0;
      case (state_reg)
         uart_cmd_pkg::RX_IDLE:
            // Only a falling edge starts a frame so a low line after a bad stop is ignored
            if (rx_prev && !rx_sync)
            begin
               state_next = uart_cmd_pkg::RX_START;
               s_next     = '0;
            end
         uart_cmd_pkg::RX_START:
            if (s_tick)
            begin
               if (s_reg == S_W'(7))
               begin
                  // High at mid start bit means a glitch
                  if (rx_sync)
                  begin
                     state_next = uart_cmd_pkg::RX_IDLE;
                  end
                  else
                  begin
                     state_next = uart_cmd_pkg::RX_DATA;
                     s_next     = '0;
                     n_next     = '0;
                  end
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         uart_cmd_pkg::RX_DATA:
            if (s_tick)
            begin
               if (s_reg == S_W'(15))
               begin
                  s_next      = '0;
                  // LSB arrives first
                  buffer_next = {rx_sync, buffer[DB-1:1]};
                  if (n_reg == N_W'(DB - 1))
                  begin
                     state_next = uart_cmd_pkg::RX_STOP;
                  end
                  else
                  begin
                     n_next = n_reg + 1'b1;
                  end
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         uart_cmd_pkg::RX_STOP:
            if (s_tick)
            begin
               if (s_reg == S_W'(SB - 1))
               begin
                  // Low line at mid stop bit flags the frame
                  state_next = uart_cmd_pkg::RX_IDLE;
                  ferr_next  = !rx_sync;
                  done_next  = 1'b1;
               end
               else
               begin
                  s_next = s_reg + 1'b1;
               end
            end
         default:
            state_next = uart_cmd_pkg::RX_IDLE;
      endcase
   end

   // Entry is stable while the done tick is high
   assign rx_entry.frame_err = ferr_reg;
   assign rx_entry.data      = buffer;

   // Bit timing counts one step per tick so ticks must be single-cycle pulses
   tick_single: assert property (@(posedge i_clk) disable iff (reset)
      s_tick |=> !s_tick);

endmodule

//--- rtl/rx_fifo.sv
`timescale 1ns/1ps
`include "uart_cmd_cfg.svh"

module rx_fifo
   (
   input  logic                     i_clk,
   input  logic                     reset,
   input  logic                     push,
   input  uart_cmd_pkg::rx_entry_t  push_entry,
   input  logic                     pop,
   output uart_cmd_pkg::rx_entry_t  head,
   output logic                     empty,
   output logic                     overflow
   );

   localparam int AW    = `RX_FIFO_AW;
   localparam int DEPTH = 1 << AW;

   // Storage
   uart_cmd_pkg::rx_entry_t  mem [0:DEPTH-1];

   // Extra MSB separates full from empty
   logic [AW:0]  wr_ptr, rd_ptr;
   logic         full;
   logic         do_push, do_pop;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   // Push when full is dropped
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   ////////////////////////////////////////
   // Storage write
   ////////////////////////////////////////
   always_ff @(posedge i_clk)
   begin
      if (do_push)
      begin
         mem[wr_ptr[AW-1:0]] <= push_entry;
      end
   end

   // Show-ahead read of the oldest entry
   assign head = mem[rd_ptr[AW-1:0]];

   ////////////////////////////////////////
   // Pointers and overflow
   ////////////////////////////////////////
   always_ff @(posedge i_clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         overflow <= 1'b0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Sticky until reset
         if (push && full)
         begin
            overflow <= 1'b1;
         end
      end
   end

   // Consumer only pops a valid head
   no_pop_empty: assert property (@(posedge i_clk) disable iff (reset)
      pop |-> !empty);

endmodule

//--- rtl/cmd_exec.sv
`timescale 1ns/1ps

module cmd_exec
   (
   input  logic                     i_clk,
   input  logic                     reset,
   input  uart_cmd_pkg::rx_entry_t  head,
   input  logic                     empty,
   output logic                     pop,
   output logic [7:0]               acc_value,
   output logic                     cmd_done,
   output logic [7:0]               bad_count
   );

   uart_cmd_pkg::exec_state_t  state_reg, state_next;
   uart_cmd_pkg::cmd_op_t      op_reg, op_next;
   logic [7:0]                 acc_next;
   logic                       done_next;
   // Bad opcode or flagged frame this cycle
   logic                       bad_hit;

   // Take every entry as soon as it shows
   assign pop = !empty;

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////
   always_comb
   begin
      state_next = state_reg;
      op_next    = op_reg;
      acc_next   = acc_value;
      done_next  = 1'b0;
      bad_hit    = 1'b0;
      if (pop)
      begin
         case (state_reg)
            uart_cmd_pkg::EX_OPCODE:
               if (head.frame_err)
               begin
                  bad_hit = 1'b1;
               end
               else
               begin
                  case (head.data)
                     uart_cmd_pkg::OP_CLR:
                     begin
                        // No operand
                        acc_next  = '0;
                        done_next = 1'b1;
                     end
                     uart_cmd_pkg::OP_SET:
                     begin
                        op_next    = uart_cmd_pkg::OP_SET;
                        state_next = uart_cmd_pkg::EX_OPERAND;
                     end
                     uart_cmd_pkg::OP_ADD:
                     begin
                        op_next    = uart_cmd_pkg::OP_ADD;
                        state_next = uart_cmd_pkg::EX_OPERAND;
                     end
                     default:
                        bad_hit = 1'b1;
                  endcase
               end
            uart_cmd_pkg::EX_OPERAND:
            begin
               // Back to opcode either way
               state_next = uart_cmd_pkg::EX_OPCODE;
               if (head.frame_err)
               begin
                  bad_hit = 1'b1;
               end
               else
               begin
                  // Add wraps modulo 256
                  if (op_reg == uart_cmd_pkg::OP_ADD)
                     acc_next = acc_value + head.data;
                  else
                     acc_next = head.data;
                  done_next = 1'b1;
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // State and accumulator
   ////////////////////////////////////////
   always_ff @(posedge i_clk or posedge reset)
   begin
      if (reset)
      begin
         state_reg <= uart_cmd_pkg::EX_OPCODE;
         op_reg    <= uart_cmd_pkg::OP_SET;
         acc_value <= '0;
         cmd_done  <= 1'b0;
         bad_count <= '0;
      end
      else
      begin
         state_reg <= state_next;
         op_reg    <= op_next;
         acc_value <= acc_next;
         cmd_done  <= done_next;
         // Saturate at 255
         if (bad_hit && (bad_count != 8'hFF))
         begin
            bad_count <= bad_count + 1'b1;
         end
      end
   end

   // Frames arrive far apart, so completions never run back to back
   done_single: assert property (@(posedge i_clk) disable iff (reset)
      cmd_done |=> !cmd_done);

endmodule

//--- rtl/uart_cmd_top.sv
`timescale 1ns/1ps

module uart_cmd_top
   (
   input  logic        i_clk,
   input  logic        reset,
   input  logic        rx,
   output logic [7:0]  acc_value,
   output logic        cmd_done,
   output logic [7:0]  bad_count,
   output logic        overflow
   );

   ////////////////////////////////////////
   // Interconnect
   ////////////////////////////////////////
   logic                     s_tick;
   // Receiver to FIFO
   logic                     rx_done_tick;
   uart_cmd_pkg::rx_entry_t  rx_entry;
   // FIFO to executor
   uart_cmd_pkg::rx_entry_t  head;
   logic                     empty;
   logic                     pop;

   // Oversampling tick, 16 per bit
   baud_tick_gen baud_tick_gen_inst
   (
      .i_clk   (i_clk),
      .reset   (reset),
      .s_tick  (s_tick)
   );

   // Serial line to bytes
   uart_rx uart_rx_inst
   (
      .i_clk         (i_clk),
      .reset         (reset),
      .rx            (rx),
      .s_tick        (s_tick),
      .rx_done_tick  (rx_done_tick),
      .rx_entry      (rx_entry)
   );

   // Byte buffer, done tick is the write strobe
   rx_fifo rx_fifo_inst
   (
      .i_clk       (i_clk),
      .reset       (reset),
      .push        (rx_done_tick),
      .push_entry  (rx_entry),
      .pop         (pop),
      .head        (head),
      .empty       (empty),
      .overflow    (overflow)
   );

   // Command parser and accumulator
   cmd_exec cmd_exec_inst
   (
      .i_clk      (i_clk),
      .reset      (reset),
      .head       (head),
      .empty      (empty),
      .pop        (pop),
      .acc_value  (acc_value),
      .cmd_done   (cmd_done),
      .bad_count  (bad_count)
   );

endmodule

//--- bench/uart_cmd_tb.sv
`timescale 1ns/1ps
`include "uart_cmd_cfg.svh"

module uart_cmd_tb;

   // Clocks per serial bit, 16 ticks each
   localparam int BIT_CLKS = 16 * `UART_TICK_DIV;
   localparam longint BIT_NS = longint'(BIT_CLKS) * 20;
   // Upper bound on frames over all tests, test 6 counted at 2 frames per command
   localparam int MAX_FRAMES = 340;
   // 10 bits per frame plus half again
   localparam longint WATCHDOG_NS = longint'(MAX_FRAMES) * 10 * BIT_NS * 3 / 2;

   logic        i_clk = 1'b0;
   logic        reset;
   logic        rx;
   logic [7:0]  acc_value;
   logic        cmd_done;
   logic [7:0]  bad_count;
   logic        overflow;

   // Reference model state
   logic [7:0]  exp_acc = 8'h00;
   logic [7:0]  exp_bad = 8'h00;
   int          exp_done = 0;
   int          seen_done = 0;

   integer      seed;
   int          test_errors = 0;
   int          total_errors = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;

   uart_cmd_top uart_cmd_top_inst
   (
      .i_clk      (i_clk),
      .reset      (reset),
      .rx         (rx),
      .acc_value  (acc_value),
      .cmd_done   (cmd_done),
      .bad_count  (bad_count),
      .overflow   (overflow)
   );

   // 20 ns period
   always #10 i_clk = ~i_clk;

   ////////////////////////////////////////
   // Checking
   ////////////////////////////////////////
   task automatic check_value(input int actual, input int expected, input string what);
      if (actual != expected)
      begin
         $display("error at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
                  expected);
         test_errors  = test_errors + 1;
         total_errors = total_errors + 1;
      end
   endtask

   // Mid-cycle look at every completion
   always @(negedge i_clk)
   begin
      if (!reset && cmd_done)
      begin
         seen_done = seen_done + 1;
         check_value(int'(acc_value), int'(exp_acc), "acc_value at cmd_done");
      end
   end

   // Bad count saturates at 255
   task automatic bump_bad();
      if (exp_bad != 8'hFF)
         exp_bad = exp_bad + 8'd1;
   endtask

   ////////////////////////////////////////
   // Serial line driver
   ////////////////////////////////////////
   task automatic drive_bit(input logic b);
      @(posedge i_clk);
      #1 rx = b;
      repeat (BIT_CLKS - 1) @(posedge i_clk);
   endtask

   task automatic send_frame(input logic [7:0] data, input logic bad_stop);
      int i;
      drive_bit(1'b0);
      // LSB first
      for (i = 0; i < `UART_DATA_BITS; i++)
         drive_bit(data[i]);
      drive_bit(!bad_stop);
      // Line back high so the next start bit has a falling edge
      if (bad_stop)
         drive_bit(1'b1);
   endtask

   task automatic random_byte(output logic [7:0] b);
      logic [31:0] r;
      r = $random(seed);
      b = r[7:0];
   endtask

   // Any byte that is not one of the three opcodes
   task automatic pick_junk(output logic [7:0] b);
      random_byte(b);
      while (b == uart_cmd_pkg::OP_SET || b == uart_cmd_pkg::OP_ADD ||
             b == uart_cmd_pkg::OP_CLR)
         random_byte(b);
   endtask

   ////////////////////////////////////////
   // Commands with model update
   ////////////////////////////////////////
   // Model moves before the completing byte goes out
   task automatic send_set(input logic [7:0] v);
      send_frame(uart_cmd_pkg::OP_SET, 1'b0);
      exp_acc  = v;
      exp_done = exp_done + 1;
      send_frame(v, 1'b0);
   endtask

   task automatic send_add(input logic [7:0] v);
      send_frame(uart_cmd_pkg::OP_ADD, 1'b0);
      exp_acc  = exp_acc + v;
      exp_done = exp_done + 1;
      send_frame(v, 1'b0);
   endtask

   task automatic send_clr();
      exp_acc  = 8'h00;
      exp_done = exp_done + 1;
      send_frame(uart_cmd_pkg::OP_CLR, 1'b0);
   endtask

   task automatic send_junk(input logic [7:0] b);
      bump_bad();
      send_frame(b, 1'b0);
   endtask

   // Let the last byte drain, then compare levels
   task automatic end_test(input int num, input string name);
      repeat (8) @(posedge i_clk);
      @(negedge i_clk);
      check_value(int'(acc_value), int'(exp_acc), "acc_value at end of test");
      check_value(int'(bad_count), int'(exp_bad), "bad_count at end of test");
      check_value(seen_done, exp_done, "number of cmd_done pulses");
      check_value(int'(overflow), 0, "overflow");
      if (test_errors == 0)
         tests_passed = tests_passed + 1;
      else
         tests_failed = tests_failed + 1;
      $display("test %0d %s: %s", num, name, (test_errors == 0) ? "ok" : "FAILED");
      test_errors = 0;
   endtask

   ////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////
   initial
   begin
      #(WATCHDOG_NS);
      $display("Simulation timed out after %0d ns, a frame never completed", WATCHDOG_NS);
      $display("Test failures found");
      $finish;
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial
   begin
      logic [7:0]  v;
      logic [31:0] r;
      int          n;
      seed  = 32'h6ecd;
      rx    = 1'b1;
      reset = 1'b1;
      repeat (2) @(posedge i_clk);
      #1 reset = 1'b0;
      drive_bit(1'b1);

      // SET loads operand
      random_byte(v);
      send_set(v);
      end_test(1, "set");

      // ADD chain wraps
      random_byte(v);
      send_set(v);
      for (n = 0; n < 8; n++)
      begin
         random_byte(v);
         send_add(v);
      end
      end_test(2, "add chain");

      // CLR takes no operand
      random_byte(v);
      send_set(v);
      send_clr();
      end_test(3, "clr");

      // Junk bytes only bump the bad count
      for (n = 0; n < 5; n++)
      begin
         pick_junk(v);
         send_junk(v);
      end
      end_test(4, "junk bytes");

      // Low stop bit on an opcode, then on an operand
      bump_bad();
      send_frame(uart_cmd_pkg::OP_SET, 1'b1);
      random_byte(v);
      send_set(v);
      send_frame(uart_cmd_pkg::OP_ADD, 1'b0);
      bump_bad();
      random_byte(v);
      send_frame(v, 1'b1);
      random_byte(v);
      send_add(v);
      end_test(5, "frame error");

      // Random mix
      for (n = 0; n < 150; n++)
      begin
         r = $random(seed);
         random_byte(v);
         case (r[1:0])
            2'd0: send_set(v);
            2'd1: send_add(v);
            2'd2: send_clr();
            default:
            begin
               pick_junk(v);
               send_junk(v);
            end
         endcase
      end
      end_test(6, "random commands");

      $display("Summary: %0d tests passed, %0d tests failed, %0d errors", tests_passed,
               tests_failed, total_errors);
      if (tests_failed == 0 && total_errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

//--- files.f
+incdir+include
rtl/uart_cmd_pkg.sv
rtl/baud_tick_gen.sv
rtl/uart_rx.sv
rtl/rx_fifo.sv
rtl/cmd_exec.sv
rtl/uart_cmd_top.sv
bench/uart_cmd_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the UART command receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f files.f --top-module uart_cmd_tb \
   -o sim_uart_cmd > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_uart_cmd > sim.log 2>&1
cat sim.log

grep -qx 'All tests passed!' sim.log && echo "Simulation PASS" \
   || { echo "Simulation FAIL"; exit 1; }
